// File: rtl/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

`define RV_XLEN  32
`define RV_NREGS 32

//////////////////////////////////////////////////
// Major opcodes
//////////////////////////////////////////////////
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

// funct7 groups
`define RV_FUNCT7_BASE   7'b0000000
`define RV_FUNCT7_ALT    7'b0100000  // sub and sra
`define RV_FUNCT7_MULDIV 7'b0000001

// ALU funct3
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

`define RV_NOP 32'h0000_0013  // addi x0, x0, 0

`endif

// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

   //////////////////////////////////////////////////
   // Instruction formats, MSB first
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rtype_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } itype_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } stype_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } btype_t;

   typedef struct packed {
      logic [19:0] imm;      // Bits 31:12 of the result
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } utype_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jtype_t;

   // Same 32 bits, six readings
   typedef union packed {
      logic [31:0] raw;
      rtype_t      r;
      itype_t      i;
      stype_t      s;
      btype_t      b;
      utype_t      u;
      jtype_t      j;
   } instr_u;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
   } alu_op_e;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_MDU} wb_sel_e;

   typedef enum logic [1:0] {BR_NONE, BR_BRANCH, BR_JAL, BR_JALR} br_op_e;

   typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

endpackage

// File: rtl/instr_latch.sv
`include "rv_decode_defines.svh"

module instr_latch import rv_decode_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [31:0] instr_i,
   input  logic [29:0] pc_i,    // Word address
   input  logic        hold_i,
   input  logic        flush_i,
   output instr_u      instr_o,
   output logic [29:0] pc_o
);

   //////////////////////////////////////////////////
   // Fetch to decode register
   //////////////////////////////////////////////////

   // Flush wins over hold, so a taken branch
   // never leaves a stale word behind
   always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
         instr_o.raw <= `RV_NOP;
         pc_o        <= '0;
      end else if (!hold_i) begin
         instr_o.raw <= instr_i;
         pc_o        <= pc_i;
      end
   end

endmodule

// File: rtl/instr_decoder.sv
`include "rv_decode_defines.svh"

module instr_decoder import rv_decode_pkg::*; (
   input  instr_u    instr_i,
   input  logic      m_supported_i,
   output alu_op_e   alu_op_o,
   output logic      op1_pc_o,
   output logic      op2_imm_o,
   output wb_sel_e   wb_sel_o,
   output logic      reg_wr_o,
   output logic      is_load_o,
   output logic      is_store_o,
   output br_op_e    br_op_o,
   output logic      mdu_en_o,
   output imm_kind_e imm_kind_o,
   output logic      illegal_o
);

   // funct3 to ALU op, alt picks sub / sra
   function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
      case (f3)
         `RV_F3_ADD:  alu_of = alt ? ALU_SUB : ALU_ADD;
         `RV_F3_SLL:  alu_of = ALU_SLL;
         `RV_F3_SLT:  alu_of = ALU_SLT;
         `RV_F3_SLTU: alu_of = ALU_SLTU;
         `RV_F3_XOR:  alu_of = ALU_XOR;
         `RV_F3_SR:   alu_of = alt ? ALU_SRA : ALU_SRL;
         `RV_F3_OR:   alu_of = ALU_OR;
         default:     alu_of = ALU_AND;
      endcase
   endfunction

   logic [2:0] f3;
   logic [6:0] f7;

   assign f3 = instr_i.r.funct3;
   assign f7 = instr_i.r.funct7;

   always_comb begin
      alu_op_o   = ALU_ADD;
      op1_pc_o   = 1'b0;
      op2_imm_o  = 1'b0;
      wb_sel_o   = WB_ALU;
      reg_wr_o   = 1'b0;
      is_load_o  = 1'b0;
      is_store_o = 1'b0;
      br_op_o    = BR_NONE;
      mdu_en_o   = 1'b0;
      imm_kind_o = IMM_I;
      illegal_o  = 1'b0;

      case (instr_i.r.opcode)
         `RV_OP_LUI: begin
            alu_op_o   = ALU_PASS_B;
            op2_imm_o  = 1'b1;
            reg_wr_o   = 1'b1;
            imm_kind_o = IMM_U;
         end
         `RV_OP_AUIPC: begin
            op1_pc_o   = 1'b1;
            op2_imm_o  = 1'b1;
            reg_wr_o   = 1'b1;
            imm_kind_o = IMM_U;
         end
         `RV_OP_JAL: begin  // ALU forms pc + imm
            op1_pc_o   = 1'b1;
            op2_imm_o  = 1'b1;
            wb_sel_o   = WB_PC4;
            reg_wr_o   = 1'b1;
            br_op_o    = BR_JAL;
            imm_kind_o = IMM_J;
         end
         `RV_OP_JALR: begin
            op2_imm_o  = 1'b1;
            wb_sel_o   = WB_PC4;
            reg_wr_o   = 1'b1;
            br_op_o    = BR_JALR;
            illegal_o  = (f3 != 3'b000);
         end
         `RV_OP_BRANCH: begin
            op1_pc_o   = 1'b1;
            op2_imm_o  = 1'b1;
            br_op_o    = BR_BRANCH;
            imm_kind_o = IMM_B;
            illegal_o  = (f3[2:1] == 2'b01);  // No beq/bne variants at 010/011
         end
         `RV_OP_LOAD: begin
            op2_imm_o  = 1'b1;
            wb_sel_o   = WB_MEM;
            reg_wr_o   = 1'b1;
            is_load_o  = 1'b1;
            illegal_o  = (f3 == 3'b011) || (f3[2:1] == 2'b11);
         end
         `RV_OP_STORE: begin
            op2_imm_o  = 1'b1;
            is_store_o = 1'b1;
            imm_kind_o = IMM_S;
            illegal_o  = (f3[2] || f3 == 3'b011);
         end
         `RV_OP_IMM: begin
            op2_imm_o  = 1'b1;
            reg_wr_o   = 1'b1;
            // Bit 30 is only a selector for the right shift
            alu_op_o   = alu_of(f3, (f3 == `RV_F3_SR) && f7[5]);
            if (f3 == `RV_F3_SLL)
               illegal_o = (f7 != `RV_FUNCT7_BASE);
            else if (f3 == `RV_F3_SR)
               illegal_o = (f7 != `RV_FUNCT7_BASE) && (f7 != `RV_FUNCT7_ALT);
         end
         `RV_OP_REG: begin
            reg_wr_o = 1'b1;
            case (f7)
               `RV_FUNCT7_MULDIV: begin
                  mdu_en_o  = m_supported_i;
                  wb_sel_o  = WB_MDU;
                  illegal_o = !m_supported_i;
               end
               `RV_FUNCT7_BASE: alu_op_o = alu_of(f3, 1'b0);
               `RV_FUNCT7_ALT: begin
                  alu_op_o  = alu_of(f3, 1'b1);
                  illegal_o = (f3 != `RV_F3_ADD) && (f3 != `RV_F3_SR);
               end
               default: illegal_o = 1'b1;
            endcase
         end
         default: illegal_o = 1'b1;
      endcase
   end

endmodule

// File: rtl/imm_gen.sv
`include "rv_decode_defines.svh"

module imm_gen import rv_decode_pkg::*; (
   input  instr_u                instr_i,
   input  imm_kind_e             kind_i,
   output logic [`RV_XLEN-1:0]   imm_o
);

   //////////////////////////////////////////////////
   // Immediate assembly per format
   //////////////////////////////////////////////////

   always_comb begin
      case (kind_i)
         IMM_I: imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
         IMM_S: imm_o = {{20{instr_i.s.imm_hi[6]}},
                         instr_i.s.imm_hi,
                         instr_i.s.imm_lo};
         IMM_B: imm_o = {{19{instr_i.b.imm12}},
                         instr_i.b.imm12,
                         instr_i.b.imm11,
                         instr_i.b.imm10_5,
                         instr_i.b.imm4_1,
                         1'b0};                // Halfword aligned
         IMM_U: imm_o = {instr_i.u.imm, 12'b0};
         IMM_J: imm_o = {{11{instr_i.j.imm20}},
                         instr_i.j.imm20,
                         instr_i.j.imm19_12,
                         instr_i.j.imm11,
                         instr_i.j.imm10_1,
                         1'b0};
         default: imm_o = '0;  // Unused kind codes
      endcase
   end

endmodule

// File: rtl/reg_file.sv
`include "rv_decode_defines.svh"

module reg_file (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [4:0]          wr_addr_i,
   input  logic [`RV_XLEN-1:0] wr_data_i,
   input  logic [4:0]          rs1_addr_i,
   input  logic [4:0]          rs2_addr_i,
   output logic [`RV_XLEN-1:0] rs1_data_o,
   output logic [`RV_XLEN-1:0] rs2_data_o
);

   logic [`RV_XLEN-1:0] regs [`RV_NREGS];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int k = 0; k < `RV_NREGS; k++)
            regs[k] <= '0;
      end else if (wr_addr_i != 5'd0) begin  // x0 never stored
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // Write-first read, the same-edge writeback is visible
   function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
      if (addr == 5'd0)
         read_port = '0;
      else if (addr == wr_addr_i)
         read_port = wr_data_i;
      else
         read_port = regs[addr];
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
   end

endmodule

// File: rtl/hazard_unit.sv
module hazard_unit (
   input  logic       ex_is_load_i,   // Load now leaving toward execute
   input  logic [4:0] ex_rd_i,
   input  logic [4:0] rs1_i,          // Sources of the decoding word
   input  logic [4:0] rs2_i,
   input  logic       branching_i,
   output logic       stall_o
);

   logic rd_match;

   // x0 is never a real dependency
   assign rd_match = (ex_rd_i != 5'd0) &&
                     ((ex_rd_i == rs1_i) || (ex_rd_i == rs2_i));

   // A flush discards the dependent word anyway
   assign stall_o = ex_is_load_i && rd_match && !branching_i;

endmodule

// File: rtl/decode_stage.sv
`include "rv_decode_defines.svh"

module decode_stage import rv_decode_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_i,
   input  instr_u              instr_i,
   input  logic [29:0]         pc_i,
   input  logic                busywait_i,
   input  logic                branching_i,
   input  logic                m_supported_i,
   input  logic [4:0]          wb_rd_i,
   input  logic [`RV_XLEN-1:0] wb_data_i,
   output logic                load_stall_o,

   output logic [29:0]         pc_o,
   output logic [`RV_XLEN-1:0] rs1_value_o,
   output logic [`RV_XLEN-1:0] rs2_value_o,
   output logic [`RV_XLEN-1:0] imm_o,
   output alu_op_e             alu_op_o,
   output logic                op1_pc_o,
   output logic                op2_imm_o,
   output wb_sel_e             wb_sel_o,
   output logic [4:0]          rd_o,
   output logic [4:0]          rs1_o,
   output logic [4:0]          rs2_o,
   output logic [2:0]          funct3_o,
   output logic                is_load_o,
   output logic                is_store_o,
   output br_op_e              br_op_o,
   output logic                mdu_en_o,
   output logic                illegal_o
);

   alu_op_e             alu_op;
   wb_sel_e             wb_sel;
   br_op_e              br_op;
   imm_kind_e           imm_kind;
   logic                op1_pc, op2_imm, reg_wr;
   logic                is_load, is_store, mdu_en, illegal;
   logic [`RV_XLEN-1:0] rs1_value, rs2_value, imm;
   logic                bubble;

   instr_decoder u_decoder (
      .instr_i       (instr_i),
      .m_supported_i (m_supported_i),
      .alu_op_o      (alu_op),
      .op1_pc_o      (op1_pc),
      .op2_imm_o     (op2_imm),
      .wb_sel_o      (wb_sel),
      .reg_wr_o      (reg_wr),
      .is_load_o     (is_load),
      .is_store_o    (is_store),
      .br_op_o       (br_op),
      .mdu_en_o      (mdu_en),
      .imm_kind_o    (imm_kind),
      .illegal_o     (illegal)
   );

   imm_gen u_imm_gen (
      .instr_i (instr_i),
      .kind_i  (imm_kind),
      .imm_o   (imm)
   );

   reg_file u_reg_file (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_addr_i  (wb_rd_i),
      .wr_data_i  (wb_data_i),
      .rs1_addr_i (instr_i.r.rs1),
      .rs2_addr_i (instr_i.r.rs2),
      .rs1_data_o (rs1_value),
      .rs2_data_o (rs2_value)
   );

   // Checked against the bundle already registered for execute
   hazard_unit u_hazard (
      .ex_is_load_i (is_load_o),
      .ex_rd_i      (rd_o),
      .rs1_i        (instr_i.r.rs1),
      .rs2_i        (instr_i.r.rs2),
      .branching_i  (branching_i),
      .stall_o      (load_stall_o)
   );

   //////////////////////////////////////////////////
   // Execute bundle
   //////////////////////////////////////////////////

   // Busywait outranks the load stall and freezes the bundle
   assign bubble = rst_i || branching_i || (!busywait_i && load_stall_o);

   always_ff @(posedge clk_i) begin
      if (bubble) begin
         alu_op_o   <= ALU_ADD;
         op1_pc_o   <= 1'b0;
         op2_imm_o  <= 1'b0;
         wb_sel_o   <= WB_ALU;
         rd_o       <= 5'd0;
         rs1_o      <= 5'd0;
         rs2_o      <= 5'd0;
         funct3_o   <= 3'd0;
         is_load_o  <= 1'b0;
         is_store_o <= 1'b0;
         br_op_o    <= BR_NONE;
         mdu_en_o   <= 1'b0;
         illegal_o  <= 1'b0;
      end else if (!busywait_i) begin
         // Illegal words run as a bubble with only the flag kept
         alu_op_o   <= illegal ? ALU_ADD : alu_op;
         op1_pc_o   <= op1_pc && !illegal;
         op2_imm_o  <= op2_imm && !illegal;
         wb_sel_o   <= illegal ? WB_ALU : wb_sel;
         rd_o       <= (reg_wr && !illegal) ? instr_i.r.rd : 5'd0;
         rs1_o      <= instr_i.r.rs1;
         rs2_o      <= instr_i.r.rs2;
         funct3_o   <= instr_i.r.funct3;
         is_load_o  <= is_load && !illegal;
         is_store_o <= is_store && !illegal;
         br_op_o    <= illegal ? BR_NONE : br_op;
         mdu_en_o   <= mdu_en && !illegal;
         illegal_o  <= illegal;
      end
   end

   // Data half, meaningless under a bubble
   always_ff @(posedge clk_i) begin
      if (!busywait_i) begin
         pc_o        <= pc_i;
         rs1_value_o <= rs1_value;
         rs2_value_o <= rs2_value;
         imm_o       <= imm;
      end
   end

endmodule

// File: rtl/decode_top.sv
`include "rv_decode_defines.svh"

module decode_top import rv_decode_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [31:0]         instr_i,
   input  logic [29:0]         pc_i,
   input  logic                busywait_i,
   input  logic                branching_i,
   input  logic                m_supported_i,
   input  logic [4:0]          wb_rd_i,
   input  logic [`RV_XLEN-1:0] wb_data_i,

   output logic [29:0]         pc_o,
   output logic [`RV_XLEN-1:0] rs1_value_o,
   output logic [`RV_XLEN-1:0] rs2_value_o,
   output logic [`RV_XLEN-1:0] imm_o,
   output alu_op_e             alu_op_o,
   output logic                op1_pc_o,
   output logic                op2_imm_o,
   output wb_sel_e             wb_sel_o,
   output logic [4:0]          rd_o,
   output logic [4:0]          rs1_o,
   output logic [4:0]          rs2_o,
   output logic [2:0]          funct3_o,
   output logic                is_load_o,
   output logic                is_store_o,
   output br_op_e              br_op_o,
   output logic                mdu_en_o,
   output logic                illegal_o,
   output logic                load_stall_o
);

   instr_u      if_instr;
   logic [29:0] if_pc;
   logic        latch_hold;

   // Memory back-pressure or a load-use stall keeps the fetched word
   assign latch_hold = busywait_i || load_stall_o;

   instr_latch u_instr_latch (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .instr_i (instr_i),
      .pc_i    (pc_i),
      .hold_i  (latch_hold),
      .flush_i (branching_i),
      .instr_o (if_instr),
      .pc_o    (if_pc)
   );

   decode_stage u_decode_stage (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .instr_i       (if_instr),
      .pc_i          (if_pc),
      .busywait_i    (busywait_i),
      .branching_i   (branching_i),
      .m_supported_i (m_supported_i),
      .wb_rd_i       (wb_rd_i),
      .wb_data_i     (wb_data_i),
      .load_stall_o  (load_stall_o),
      .pc_o          (pc_o),
      .rs1_value_o   (rs1_value_o),
      .rs2_value_o   (rs2_value_o),
      .imm_o         (imm_o),
      .alu_op_o      (alu_op_o),
      .op1_pc_o      (op1_pc_o),
      .op2_imm_o     (op2_imm_o),
      .wb_sel_o      (wb_sel_o),
      .rd_o          (rd_o),
      .rs1_o         (rs1_o),
      .rs2_o         (rs2_o),
      .funct3_o      (funct3_o),
      .is_load_o     (is_load_o),
      .is_store_o    (is_store_o),
      .br_op_o       (br_op_o),
      .mdu_en_o      (mdu_en_o),
      .illegal_o     (illegal_o)
   );

endmodule

// File: testbench/tb_decode_top.sv
`include "rv_decode_defines.svh"

module tb_decode_top import rv_decode_pkg::*; ();

   // Table row, flags = {op1 is pc, imm valid, load, store, mdu, illegal}
   typedef struct packed {
      logic [31:0] instr;
      logic [29:0] pc;
      logic [2:0]  stim;    // busywait, branching, m_supported
      logic [4:0]  rd;
      alu_op_e     alu;
      logic [31:0] imm;
      wb_sel_e     wb;
      br_op_e      brop;
      logic [5:0]  flags;
   } vec_t;

   localparam int NVEC = 16;

   logic        clk_i, rst_i;
   logic [31:0] instr_i;
   logic [29:0] pc_i;
   logic        busywait_i, branching_i, m_supported_i;
   logic [4:0]  wb_rd_i;
   logic [31:0] wb_data_i;
   logic [29:0] pc_o;
   logic [31:0] rs1_value_o, rs2_value_o, imm_o;
   alu_op_e     alu_op_o;
   logic        op1_pc_o, op2_imm_o;
   wb_sel_e     wb_sel_o;
   logic [4:0]  rd_o, rs1_o, rs2_o;
   logic [2:0]  funct3_o;
   logic        is_load_o, is_store_o, mdu_en_o, illegal_o, load_stall_o;
   br_op_e      br_op_o;

   vec_t        t [NVEC];
   logic [31:0] model [32];   // Expected register contents
   integer      seed;
   int          errors = 0;
   int          checks = 0;

   decode_top dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // Overall limit on the run
   initial begin
      #20000;
      $display("timeout: the run did not reach its end");
      $display("Simulation finished: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////
   task automatic fill_table;
      t[0]  = '{32'hFFB10093, 30'h100, 3'b001,                 // addi x1, x2, -5
                5'd1, ALU_ADD, 32'hFFFFFFFB, WB_ALU, BR_NONE, 6'b010000};
      t[1]  = '{32'h405201B3, 30'h101, 3'b001,                 // sub x3, x4, x5
                5'd3, ALU_SUB, 32'h0, WB_ALU, BR_NONE, 6'b000000};
      t[2]  = '{32'h01042383, 30'h102, 3'b001,                 // lw x7, 16(x8)
                5'd7, ALU_ADD, 32'h00000010, WB_MEM, BR_NONE, 6'b011000};
      t[3]  = '{32'hFE952C23, 30'h103, 3'b001,                 // sw x9, -8(x10)
                5'd0, ALU_ADD, 32'hFFFFFFF8, WB_ALU, BR_NONE, 6'b010100};
      t[4]  = '{32'hFEC588E3, 30'h104, 3'b001,                 // beq x11, x12, -16
                5'd0, ALU_ADD, 32'hFFFFFFF0, WB_ALU, BR_BRANCH, 6'b110000};
      t[5]  = '{32'hABCDE6B7, 30'h105, 3'b001,                 // lui x13, 0xabcde
                5'd13, ALU_PASS_B, 32'hABCDE000, WB_ALU, BR_NONE, 6'b010000};
      t[6]  = '{32'h12345717, 30'h106, 3'b001,                 // auipc x14, 0x12345
                5'd14, ALU_ADD, 32'h12345000, WB_ALU, BR_NONE, 6'b110000};
      t[7]  = '{32'hFFDFF0EF, 30'h107, 3'b001,                 // jal x1, -4
                5'd1, ALU_ADD, 32'hFFFFFFFC, WB_PC4, BR_JAL, 6'b110000};
      t[8]  = '{32'h00408067, 30'h108, 3'b001,                 // jalr x0, 4(x1)
                5'd0, ALU_ADD, 32'h00000004, WB_PC4, BR_JALR, 6'b010000};
      t[9]  = '{32'h40385793, 30'h109, 3'b001,                 // srai x15, x16, 3
                5'd15, ALU_SRA, 32'h00000403, WB_ALU, BR_NONE, 6'b010000};
      t[10] = '{32'h033908B3, 30'h10A, 3'b001,                 // mul x17, x18, x19
                5'd17, ALU_ADD, 32'h0, WB_MDU, BR_NONE, 6'b000010};
      t[11] = '{32'h033908B3, 30'h10B, 3'b000,                 // mul without M
                5'd0, ALU_ADD, 32'h0, WB_ALU, BR_NONE, 6'b000001};
      t[12] = '{32'h12345677, 30'h10C, 3'b001,                 // Unknown opcode
                5'd0, ALU_ADD, 32'h0, WB_ALU, BR_NONE, 6'b000001};
      t[13] = '{32'h7FF00A13, 30'h10D, 3'b011,                 // Flushed addi x20
                5'd0, ALU_ADD, 32'h0, WB_ALU, BR_NONE, 6'b000000};
      t[14] = '{32'h01600AB3, 30'h10E, 3'b101,                 // add x21, x0, x22
                5'd21, ALU_ADD, 32'h0, WB_ALU, BR_NONE, 6'b000000};
      t[15] = '{32'h019C6BB3, 30'h10F, 3'b001,                 // or x23, x24, x25
                5'd23, ALU_OR, 32'h0, WB_ALU, BR_NONE, 6'b000000};
   endtask

   // Bit 0 for rs1, bit 1 for rs2
   function automatic logic [1:0] source_regs(input logic [6:0] opcode);
      case (opcode)
         `RV_OP_REG, `RV_OP_STORE, `RV_OP_BRANCH: source_regs = 2'b11;
         `RV_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR:    source_regs = 2'b01;
         default:                                 source_regs = 2'b00;
      endcase
   endfunction

   task automatic report_mismatch(input string tag, input string name,
                                  input logic [31:0] got, input logic [31:0] exp);
      $display("mismatch %s %s: got 0x%h expected 0x%h", tag, name, got, exp);
      errors++;
   endtask

   // Between entries the execute side must show a bubble
   task automatic check_quiet(input string tag);
      checks++;
      if (rd_o !== 5'd0 || is_load_o || is_store_o || br_op_o != BR_NONE ||
          mdu_en_o || illegal_o) begin
         $display("%s: an instruction showed up where a bubble was expected", tag);
         errors++;
      end
   endtask

   task automatic check_entry(input int idx, input vec_t e);
      string      tag;
      logic [1:0] src;
      logic       data_ok;
      tag     = $sformatf("entry %0d", idx);
      src     = source_regs(e.instr[6:0]);
      data_ok = !e.stim[1] && !e.flags[0];   // Data half is don't care in a bubble
      checks++;
      if (rd_o !== e.rd)
         report_mismatch(tag, "rd_o", 32'(rd_o), 32'(e.rd));
      if (alu_op_o !== e.alu)
         report_mismatch(tag, "alu_op_o", 32'(alu_op_o), 32'(e.alu));
      if (wb_sel_o !== e.wb)
         report_mismatch(tag, "wb_sel_o", 32'(wb_sel_o), 32'(e.wb));
      if (br_op_o !== e.brop)
         report_mismatch(tag, "br_op_o", 32'(br_op_o), 32'(e.brop));
      if ({op1_pc_o, op2_imm_o} !== e.flags[5:4])
         report_mismatch(tag, "op1_pc/op2_imm", 32'({op1_pc_o, op2_imm_o}), 32'(e.flags[5:4]));
      if ({is_load_o, is_store_o, mdu_en_o, illegal_o} !== e.flags[3:0])
         report_mismatch(tag, "load/store/mdu/illegal",
                         32'({is_load_o, is_store_o, mdu_en_o, illegal_o}), 32'(e.flags[3:0]));
      if (load_stall_o !== 1'b0)
         report_mismatch(tag, "load_stall_o", 32'(load_stall_o), 32'd0);
      // Register fields travel with every word that is not flushed
      if (!e.stim[1] && rs1_o !== e.instr[19:15])
         report_mismatch(tag, "rs1_o", 32'(rs1_o), 32'(e.instr[19:15]));
      if (!e.stim[1] && rs2_o !== e.instr[24:20])
         report_mismatch(tag, "rs2_o", 32'(rs2_o), 32'(e.instr[24:20]));
      if (!e.stim[1] && funct3_o !== e.instr[14:12])
         report_mismatch(tag, "funct3_o", 32'(funct3_o), 32'(e.instr[14:12]));
      if (data_ok && e.flags[4] && imm_o !== e.imm)
         report_mismatch(tag, "imm_o", imm_o, e.imm);
      if (data_ok && pc_o !== e.pc)
         report_mismatch(tag, "pc_o", 32'(pc_o), 32'(e.pc));
      if (data_ok && src[0] && rs1_value_o !== model[e.instr[19:15]])
         report_mismatch(tag, "rs1_value_o", rs1_value_o, model[e.instr[19:15]]);
      if (data_ok && src[1] && rs2_value_o !== model[e.instr[24:20]])
         report_mismatch(tag, "rs2_value_o", rs2_value_o, model[e.instr[24:20]]);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      vec_t e;
      int   cycles;
      seed          = 90633;
      rst_i         = 1'b1;
      instr_i       = `RV_NOP;
      pc_i          = '0;
      busywait_i    = 1'b0;
      branching_i   = 1'b0;
      m_supported_i = 1'b1;
      wb_rd_i       = 5'd0;
      wb_data_i     = '0;
      fill_table();
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      check_quiet("after reset");

      model[0] = '0;
      for (int r = 1; r < 32; r++) begin   // Preload through writeback
         wb_rd_i   = r[4:0];
         wb_data_i = $random(seed);
         model[r]  = wb_data_i;
         @(negedge clk_i);
      end
      wb_rd_i = 5'd0;

      for (int i = 0; i < NVEC; i++) begin
         e             = t[i];
         instr_i       = e.instr;
         pc_i          = e.pc;
         m_supported_i = e.stim[0];
         @(posedge clk_i);
         @(negedge clk_i);
         check_quiet($sformatf("before entry %0d", i));
         // A flushed word stays on the fetch side and must not be latched
         instr_i     = e.stim[1] ? e.instr : `RV_NOP;
         branching_i = e.stim[1];
         if (!e.stim[1]) begin
            wb_rd_i   = e.instr[19:15];   // Same-edge writeback to rs1
            wb_data_i = $random(seed);
            if (wb_rd_i != 5'd0)
               model[wb_rd_i] = wb_data_i;
         end
         @(posedge clk_i);
         @(negedge clk_i);
         branching_i = 1'b0;
         wb_rd_i     = 5'd0;
         instr_i     = `RV_NOP;
         check_entry(i, e);
         if (e.stim[2]) begin
            busywait_i = 1'b1;
            instr_i    = 32'h00100F93;   // addi x31, x0, 1 held off by busywait
            repeat (3) begin
               @(posedge clk_i);
               @(negedge clk_i);
               check_entry(i, e);   // Frozen outputs
            end
            busywait_i = 1'b0;
            instr_i    = `RV_NOP;
         end
      end

      // Load-use pair: lw x5, 0(x1) then add x6, x5, x2
      m_supported_i = 1'b1;
      instr_i       = 32'h0000A283;
      pc_i          = 30'h200;
      @(posedge clk_i);
      @(negedge clk_i);
      instr_i = 32'h00228333;
      pc_i    = 30'h201;
      @(posedge clk_i);
      @(negedge clk_i);
      instr_i = `RV_NOP;
      checks++;
      if (rd_o !== 5'd5 || !is_load_o) begin
         $display("load x5 did not reach the execute outputs");
         errors++;
      end
      if (load_stall_o !== 1'b1)
         report_mismatch("load-use", "load_stall_o", 32'(load_stall_o), 32'd1);
      cycles = 0;
      do begin
         @(posedge clk_i);
         @(negedge clk_i);
         cycles++;
         if (cycles == 1 && (rd_o !== 5'd0 || is_load_o)) begin
            $display("no bubble after the load");
            errors++;
         end
      end while (rd_o !== 5'd6 && cycles < 8);
      checks++;
      if (rd_o !== 5'd6) begin
         $display("timeout waiting for the dependent add");
         errors++;
      end else begin
         if (cycles != 2)
            report_mismatch("load-use", "cycles to add", 32'(cycles), 32'd2);
         if (rs1_value_o !== model[5])
            report_mismatch("load-use", "rs1_value_o", rs1_value_o, model[5]);
         if (rs2_value_o !== model[2])
            report_mismatch("load-use", "rs2_value_o", rs2_value_o, model[2]);
      end

      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: sim.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/instr_latch.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/decode_top.sv
testbench/tb_decode_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_decode_top -o tb_decode_top
./obj_dir/tb_decode_top | tee sim.log
if grep -q "^Simulation finished: PASS$" sim.log; then
   echo "run passed"
else
   echo "run failed"
   exit 1
fi
